/* design/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        ST_OK,
        ST_ADDR_NACK,
        ST_DATA_NACK,
        ST_BAD_CMD
    } i2c_status_e;

    // raw word from the host, write data right-aligned
    typedef struct packed {
        logic [7:0]        addr_byte;
        logic              stop;
        logic [2:0]        spare;
        logic [3:0]        count;
        logic [DATA_W-1:0] wdata;
    } host_cmd_t;

    // decoded transfer, first byte to send in the top byte
    typedef struct packed {
        logic [6:0]        addr;
        logic              rw;
        logic              stop;
        logic [2:0]        nbytes;
        logic [DATA_W-1:0] wdata;
    } i2c_cmd_t;

    typedef struct packed {
        i2c_status_e       status;
        logic [DATA_W-1:0] rdata;
    } i2c_rsp_t;

endpackage

`default_nettype wire

/* design/i2c_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_decode #(
    parameter int MAX_BYTES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_req,
    input  i2c_pkg::host_cmd_t   cmd,
    output logic                 cmd_ack,
    output logic                 xfer_req,
    output i2c_pkg::i2c_cmd_t    xfer,
    input  logic                 xfer_ack,
    output logic                 err_req,
    output i2c_pkg::i2c_status_e err_status,
    input  logic                 err_ack,
    input  logic                 rsp_busy
);
    import i2c_pkg::*;

    typedef enum logic {
        D_IDLE,
        D_ACTIVE
    } dec_state_e;

    dec_state_e state;
    logic       accept;
    logic       bad_count;
    logic [2:0] pad_bytes;

    // hold off the host while a response is still in flight
    assign accept     = (state == D_IDLE) && cmd_req && !rsp_busy;
    assign bad_count  = (cmd.count == 4'd0) || (cmd.count > 4'(MAX_BYTES));
    // unused leading bytes of the right-aligned write data
    assign pad_bytes  = 3'd4 - cmd.count[2:0];
    assign err_status = ST_BAD_CMD;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= D_IDLE;
            cmd_ack  <= 1'b0;
            xfer_req <= 1'b0;
            err_req  <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (accept) begin
                        cmd_ack  <= 1'b1;
                        xfer_req <= !bad_count;
                        err_req  <= bad_count;
                        state    <= D_ACTIVE;
                    end
                end
                default: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                    end
                    if (xfer_ack) begin
                        xfer_req <= 1'b0;
                    end
                    if (err_ack) begin
                        err_req <= 1'b0;
                    end
                    // both handshakes back to zero
                    if (!cmd_ack && !xfer_req && !err_req && !xfer_ack && !err_ack) begin
                        state <= D_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            xfer.addr   <= cmd.addr_byte[7:1];
            xfer.rw     <= cmd.addr_byte[0];
            xfer.stop   <= cmd.stop;
            xfer.nbytes <= cmd.count[2:0];
            xfer.wdata  <= cmd.wdata << {pad_bytes, 3'b000};
        end
    end

endmodule

`default_nettype wire

/* design/i2c_master_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_fsm #(
    parameter int CLK_DIV = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 xfer_req,
    input  i2c_pkg::i2c_cmd_t    xfer,
    output logic                 xfer_ack,
    output logic                 scl,
    output logic                 sda_low,
    input  logic                 sda_in,
    output logic                 byte_valid,
    output logic [7:0]           rx_byte,
    output logic                 done_req,
    output i2c_pkg::i2c_status_e done_status,
    input  logic                 done_ack
);
    import i2c_pkg::*;

    localparam int DIV_W = (CLK_DIV > 0) ? $clog2(CLK_DIV + 1) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_SHIFT,
        S_ACK,
        S_STOP,
        S_DONE,
        S_HOLD
    } fsm_state_e;

    fsm_state_e        state;
    logic [DIV_W-1:0]  div_cnt;
    logic              tick;
    logic [1:0]        step;
    logic [2:0]        bit_cnt;
    logic [7:0]        shreg;
    logic [2:0]        bytes_left;
    logic [DATA_W-1:0] tx_data;
    logic              addr_phase;
    logic              rw_q;
    logic              stop_q;
    logic              ack_bit;
    // bus left claimed after a transfer without STOP
    logic              held;

    assign tick = (div_cnt == DIV_W'(CLK_DIV));

    always_ff @(posedge clk) begin
        if (rst || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            step       <= 2'd0;
            scl        <= 1'b1;
            sda_low    <= 1'b0;
            xfer_ack   <= 1'b0;
            done_req   <= 1'b0;
            byte_valid <= 1'b0;
            held       <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (xfer_ack && !xfer_req) begin
                xfer_ack <= 1'b0;
            end
            case (state)
                S_IDLE, S_HOLD: begin
                    if (xfer_req && !xfer_ack) begin
                        xfer_ack    <= 1'b1;
                        shreg       <= {xfer.addr, xfer.rw};
                        rw_q        <= xfer.rw;
                        stop_q      <= xfer.stop;
                        bytes_left  <= xfer.nbytes;
                        tx_data     <= xfer.wdata;
                        done_status <= ST_OK;
                        // a free bus skips the sda release
                        step        <= (state == S_HOLD) ? 2'd0 : 2'd1;
                        state       <= S_START;
                    end
                end
                S_START: if (tick) begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: sda_low <= 1'b0;
                        2'd1: scl <= 1'b1;
                        2'd2: sda_low <= 1'b1;
                        default: begin
                            scl        <= 1'b0;
                            addr_phase <= 1'b1;
                            bit_cnt    <= 3'd7;
                            state      <= S_SHIFT;
                        end
                    endcase
                end
                S_SHIFT: if (tick) begin
                    step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
                    case (step)
                        2'd0: sda_low <= (addr_phase || !rw_q) ? !shreg[7] : 1'b0;
                        2'd1: begin
                            scl   <= 1'b1;
                            shreg <= {shreg[6:0], sda_in};
                        end
                        default: begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt - 3'd1;
                            if (bit_cnt == 3'd0) begin
                                state <= S_ACK;
                                if (!addr_phase && rw_q) begin
                                    byte_valid <= 1'b1;
                                    rx_byte    <= shreg;
                                end
                            end
                        end
                    endcase
                end
                S_ACK: if (tick) begin
                    step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
                    case (step)
                        // master ACKs read bytes except the last one
                        2'd0: sda_low <= !addr_phase && rw_q && (bytes_left != 3'd1);
                        2'd1: begin
                            scl     <= 1'b1;
                            ack_bit <= sda_in;
                        end
                        default: begin
                            scl <= 1'b0;
                            if (addr_phase && ack_bit) begin
                                done_status <= ST_ADDR_NACK;
                                state       <= S_STOP;
                            end else if (!addr_phase && !rw_q && ack_bit) begin
                                done_status <= ST_DATA_NACK;
                                state       <= S_STOP;
                            end else if (!addr_phase && bytes_left == 3'd1) begin
                                held     <= !stop_q;
                                done_req <= !stop_q;
                                state    <= stop_q ? S_STOP : S_DONE;
                            end else begin
                                if (!addr_phase) begin
                                    bytes_left <= bytes_left - 3'd1;
                                end
                                addr_phase <= 1'b0;
                                shreg      <= tx_data[DATA_W-1 -: 8];
                                tx_data    <= {tx_data[DATA_W-9:0], 8'h00};
                                bit_cnt    <= 3'd7;
                                state      <= S_SHIFT;
                            end
                        end
                    endcase
                end
                S_STOP: if (tick) begin
                    step <= step + 2'd1;
                    case (step)
                        2'd0: sda_low <= 1'b1;
                        2'd1: scl <= 1'b1;
                        2'd2: sda_low <= 1'b0;
                        default: begin
                            held     <= 1'b0;
                            done_req <= 1'b1;
                            state    <= S_DONE;
                        end
                    endcase
                end
                default: begin
                    if (done_req && done_ack) begin
                        done_req <= 1'b0;
                    end
                    if (!done_req && !done_ack) begin
                        state <= held ? S_HOLD : S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/i2c_result_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_result_pack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 byte_valid,
    input  logic [7:0]           rx_byte,
    input  logic                 done_req,
    input  i2c_pkg::i2c_status_e done_status,
    output logic                 done_ack,
    input  logic                 err_req,
    input  i2c_pkg::i2c_status_e err_status,
    output logic                 err_ack,
    output logic                 rsp_req,
    output i2c_pkg::i2c_rsp_t    rsp,
    input  logic                 rsp_ack,
    output logic                 rsp_busy
);
    import i2c_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_SEND,
        R_CLOSE
    } res_state_e;

    res_state_e        state;
    logic [DATA_W-1:0] acc;

    assign rsp_busy = done_req || err_req || (state != R_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= R_IDLE;
            acc      <= '0;
            done_ack <= 1'b0;
            err_ack  <= 1'b0;
            rsp_req  <= 1'b0;
        end else begin
            if (byte_valid) begin
                acc <= {acc[DATA_W-9:0], rx_byte};
            end
            if (done_ack && !done_req) begin
                done_ack <= 1'b0;
            end
            if (err_ack && !err_req) begin
                err_ack <= 1'b0;
            end
            case (state)
                R_IDLE: begin
                    // bus results take priority over decode errors
                    if (done_req && !done_ack) begin
                        done_ack   <= 1'b1;
                        rsp_req    <= 1'b1;
                        rsp.status <= done_status;
                        rsp.rdata  <= acc;
                        acc        <= '0;
                        state      <= R_SEND;
                    end else if (err_req && !err_ack) begin
                        err_ack    <= 1'b1;
                        rsp_req    <= 1'b1;
                        rsp.status <= err_status;
                        rsp.rdata  <= '0;
                        acc        <= '0;
                        state      <= R_SEND;
                    end
                end
                R_SEND: begin
                    if (rsp_ack) begin
                        rsp_req <= 1'b0;
                        state   <= R_CLOSE;
                    end
                end
                default: begin
                    if (!rsp_ack) begin
                        state <= R_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/i2c_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top #(
    parameter int CLK_DIV   = 4,
    parameter int MAX_BYTES = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_req,
    input  i2c_pkg::host_cmd_t cmd,
    output logic               cmd_ack,
    output logic               rsp_req,
    output i2c_pkg::i2c_rsp_t  rsp,
    input  logic               rsp_ack,
    output logic               scl,
    output logic               sda_low,
    input  logic               sda_in
);
    import i2c_pkg::*;

    logic        xfer_req;
    logic        xfer_ack;
    i2c_cmd_t    xfer;
    logic        err_req;
    logic        err_ack;
    i2c_status_e err_status;
    logic        byte_valid;
    logic [7:0]  rx_byte;
    logic        done_req;
    logic        done_ack;
    i2c_status_e done_status;
    logic        rsp_busy;

    i2c_cmd_decode #(
        .MAX_BYTES (MAX_BYTES)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .xfer_req   (xfer_req),
        .xfer       (xfer),
        .xfer_ack   (xfer_ack),
        .err_req    (err_req),
        .err_status (err_status),
        .err_ack    (err_ack),
        .rsp_busy   (rsp_busy)
    );

    i2c_master_fsm #(
        .CLK_DIV (CLK_DIV)
    ) u_fsm (
        .clk         (clk),
        .rst         (rst),
        .xfer_req    (xfer_req),
        .xfer        (xfer),
        .xfer_ack    (xfer_ack),
        .scl         (scl),
        .sda_low     (sda_low),
        .sda_in      (sda_in),
        .byte_valid  (byte_valid),
        .rx_byte     (rx_byte),
        .done_req    (done_req),
        .done_status (done_status),
        .done_ack    (done_ack)
    );

    i2c_result_pack u_result (
        .clk         (clk),
        .rst         (rst),
        .byte_valid  (byte_valid),
        .rx_byte     (rx_byte),
        .done_req    (done_req),
        .done_status (done_status),
        .done_ack    (done_ack),
        .err_req     (err_req),
        .err_status  (err_status),
        .err_ack     (err_ack),
        .rsp_req     (rsp_req),
        .rsp         (rsp),
        .rsp_ack     (rsp_ack),
        .rsp_busy    (rsp_busy)
    );

endmodule

`default_nettype wire

/* testbench/i2c_target_model.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] TARGET_ADDR = 7'h50
) (
    input  logic scl,
    input  logic sda,
    output logic pull
);
    typedef enum logic [2:0] {
        T_IDLE,
        T_ADDR,
        T_ACK,
        T_WRITE,
        T_READ,
        T_MACK
    } tgt_state_e;

    tgt_state_e state      = T_IDLE;
    logic [7:0] mem [4]    = '{8'h5a, 8'h5b, 8'h58, 8'h59};
    logic [7:0] shreg      = 8'h00;
    logic [3:0] bit_cnt    = 4'd0;
    logic [1:0] idx        = 2'd0;
    logic       rw         = 1'b0;
    logic       master_ack = 1'b0;
    logic       pull_q     = 1'b0;
    logic       scl_q      = 1'b1;
    logic       sda_q      = 1'b1;

    assign pull = pull_q;

    task automatic sample_bit();
        case (state)
            T_ADDR, T_WRITE: begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
            end
            T_MACK: master_ack = !sda;
            default: ;
        endcase
    endtask

    // all sda changes by the target happen while scl is low
    task automatic drive_next();
        case (state)
            T_ADDR: begin
                if (bit_cnt == 4'd8) begin
                    if (shreg[7:1] == TARGET_ADDR) begin
                        rw     = shreg[0];
                        idx    = 2'd0;
                        pull_q = 1'b1;
                        state  = T_ACK;
                    end else begin
                        state = T_IDLE;
                    end
                end
            end
            T_WRITE: begin
                if (bit_cnt == 4'd8) begin
                    mem[idx] = shreg;
                    idx      = idx + 2'd1;
                    pull_q   = 1'b1;
                    state    = T_ACK;
                end
            end
            T_ACK: begin
                bit_cnt = 4'd0;
                if (rw) begin
                    shreg  = mem[idx];
                    pull_q = !shreg[7];
                    state  = T_READ;
                end else begin
                    pull_q = 1'b0;
                    state  = T_WRITE;
                end
            end
            T_READ: begin
                bit_cnt = bit_cnt + 4'd1;
                if (bit_cnt == 4'd8) begin
                    pull_q = 1'b0;
                    state  = T_MACK;
                end else begin
                    shreg  = {shreg[6:0], 1'b0};
                    pull_q = !shreg[7];
                end
            end
            T_MACK: begin
                if (master_ack) begin
                    idx     = idx + 2'd1;
                    shreg   = mem[idx];
                    pull_q  = !shreg[7];
                    bit_cnt = 4'd0;
                    state   = T_READ;
                end else begin
                    state = T_IDLE;
                end
            end
            default: ;
        endcase
    endtask

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            // start or repeated start
            state   = T_ADDR;
            bit_cnt = 4'd0;
            pull_q  = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            state  = T_IDLE;
            pull_q = 1'b0;
        end else if (scl === 1'b1 && scl_q !== 1'b1) begin
            sample_bit();
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            drive_next();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

/* testbench/i2c_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              rsp_req,
    input  i2c_pkg::i2c_rsp_t rsp,
    input  logic              scl,
    input  logic              sda,
    output int                errors,
    output int                seen
);
    import i2c_pkg::*;

    localparam string INPUT_FILE = "testbench/i2c_input.txt";

    i2c_status_e       exp_status[$];
    logic [DATA_W-1:0] exp_rdata[$];
    logic              rsp_req_q;
    logic              scl_q;
    int                scl_falls;

    task automatic load_expected();
        int          fd;
        int          n;
        string       line;
        logic [47:0] word;
        logic [31:0] status_v;
        logic [31:0] rdata_v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("checker could not open %s", INPUT_FILE);
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h", word, status_v, rdata_v) == 3) begin
                exp_status.push_back(i2c_status_e'(status_v[1:0]));
                exp_rdata.push_back(rdata_v);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        load_expected();
    end

    task automatic check_response();
        if (seen >= exp_status.size()) begin
            $display("unexpected response at %0t, only %0d were expected",
                     $time, exp_status.size());
            errors++;
        end else begin
            if (rsp.status !== exp_status[seen] || rsp.rdata !== exp_rdata[seen]) begin
                $display("Fail at %0t: response %0d is %s %h, expected %s %h", $time, seen,
                         rsp.status.name(), rsp.rdata, exp_status[seen].name(), exp_rdata[seen]);
                errors++;
            end
            // a rejected command must never touch the bus
            if (exp_status[seen] == ST_BAD_CMD && scl_falls != 0) begin
                $display("Fail at %0t: response %0d rejected, yet scl fell %0d times",
                         $time, seen, scl_falls);
                errors++;
            end
            if ((exp_status[seen] inside {ST_BAD_CMD, ST_ADDR_NACK}) && !(scl && sda)) begin
                $display("Fail at %0t: response %0d left the bus busy, scl %b sda %b",
                         $time, seen, scl, sda);
                errors++;
            end
        end
        seen++;
        scl_falls = 0;
    endtask

    // sampled mid-cycle away from the DUT clock edge
    always @(negedge clk) begin
        if (rst) begin
            errors    = 0;
            seen      = 0;
            rsp_req_q = 1'b0;
            scl_q     = 1'b1;
            scl_falls = 0;
        end else begin
            if (scl_q && !scl) begin
                scl_falls++;
            end
            scl_q = scl;
            if (rsp_req && !rsp_req_q) begin
                check_response();
            end
            rsp_req_q = rsp_req;
        end
    end

endmodule

`default_nettype wire

/* testbench/i2c_master_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_asserts (
    input logic       clk,
    input logic       rst,
    input logic       cmd_req,
    input logic       cmd_ack,
    input logic       rsp_req,
    input logic       rsp_ack,
    input logic       scl,
    input logic [2:0] fsm_state
);
    // S_IDLE encoding of the FSM
    localparam logic [2:0] FSM_IDLE = 3'd0;

    int fails = 0;

    a_cmd_req_held: assert property (@(posedge clk) disable iff (rst)
        cmd_req && !cmd_ack |=> cmd_req)
        else begin
            fails++;
            $error("cmd_req dropped before cmd_ack");
        end

    a_rsp_req_held: assert property (@(posedge clk) disable iff (rst)
        rsp_req && !rsp_ack |=> rsp_req)
        else begin
            fails++;
            $error("rsp_req dropped before rsp_ack");
        end

    a_cmd_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            fails++;
            $error("cmd_ack rose without cmd_req");
        end

    a_rsp_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(rsp_ack) |-> rsp_req)
        else begin
            fails++;
            $error("rsp_ack rose without rsp_req");
        end

    a_idle_scl_high: assert property (@(posedge clk) disable iff (rst)
        (fsm_state == FSM_IDLE) |-> scl)
        else begin
            fails++;
            $error("scl low while the FSM is idle");
        end

endmodule

bind i2c_master_top i2c_master_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack),
    .scl       (scl),
    .fsm_state (u_fsm.state)
);

`default_nettype wire

/* testbench/tb_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master #(
    parameter int CLK_DIV = 2
);
    import i2c_pkg::*;

    localparam int    MAX_BYTES     = 4;
    localparam string INPUT_FILE    = "testbench/i2c_input.txt";
    // bit slots allowed per command
    localparam int    SLOTS_PER_CMD = 50;
    localparam int    MARGIN_CYCLES = 500;

    logic      clk;
    logic      rst;
    logic      cmd_req;
    host_cmd_t cmd;
    logic      cmd_ack;
    logic      rsp_req;
    i2c_rsp_t  rsp;
    logic      rsp_ack;
    logic      scl;
    logic      sda_low;
    logic      tgt_pull;
    logic      sda;

    host_cmd_t cmds[$];
    int        n_cmds;
    logic      cmds_loaded;
    int        tb_errors;
    logic      timed_out;
    int        chk_errors;
    int        rsp_count;

    // open drain where either side can pull sda low
    assign sda = !((sda_low === 1'b1) || tgt_pull);

    i2c_master_top #(
        .CLK_DIV   (CLK_DIV),
        .MAX_BYTES (MAX_BYTES)
    ) u_i2c_master_top (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .rsp_req (rsp_req),
        .rsp     (rsp),
        .rsp_ack (rsp_ack),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    i2c_target_model #(
        .TARGET_ADDR (7'h50)
    ) u_target (
        .scl  (scl),
        .sda  (sda),
        .pull (tgt_pull)
    );

    i2c_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .rsp_req (rsp_req),
        .rsp     (rsp),
        .scl     (scl),
        .sda     (sda),
        .errors  (chk_errors),
        .seen    (rsp_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_commands();
        int          fd;
        int          n;
        string       line;
        logic [47:0] word;
        logic [31:0] status_v;
        logic [31:0] rdata_v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", INPUT_FILE);
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // comment and blank lines do not scan
            if (n > 0 && $sscanf(line, "%h %h %h", word, status_v, rdata_v) == 3) begin
                cmds.push_back(host_cmd_t'(word));
            end
        end
        $fclose(fd);
    endtask

    // full command handshake and then the response
    task automatic run_command(input host_cmd_t c);
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        @(negedge clk);
        while (cmd_ack !== 1'b1) @(negedge clk);
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        while (cmd_ack !== 1'b0) @(negedge clk);
        while (rsp_req !== 1'b1) @(negedge clk);
        @(posedge clk);
        rsp_ack <= 1'b1;
        @(negedge clk);
        while (rsp_req !== 1'b0) @(negedge clk);
        @(posedge clk);
        rsp_ack <= 1'b0;
    endtask

    task automatic finish_run();
        int total;
        int assert_fails;
        assert_fails = u_i2c_master_top.u_asserts.fails;
        total = tb_errors + chk_errors + assert_fails;
        if (timed_out === 1'b1) begin
            total++;
        end
        if (rsp_count != n_cmds) begin
            $display("only %0d of %0d responses arrived", rsp_count, n_cmds);
            total++;
        end
        $display("errors %0d: checker %0d, assert %0d, tb %0d, timeout %0d, rsp %0d/%0d",
                 total, chk_errors, assert_fails, tb_errors, timed_out === 1'b1,
                 rsp_count, n_cmds);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        cmd_req     = 1'b0;
        cmd         = '0;
        rsp_ack     = 1'b0;
        rst         = 1'b1;
        tb_errors   = 0;
        cmds_loaded = 1'b0;
        load_commands();
        n_cmds      = cmds.size();
        cmds_loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (cmds[i]) begin
            run_command(cmds[i]);
        end
        repeat (10) @(posedge clk);
        finish_run();
    end

    // watchdog scaled to the number of commands
    initial begin
        int limit;
        timed_out = 1'b0;
        wait (cmds_loaded === 1'b1);
        limit = n_cmds * SLOTS_PER_CMD * 3 * (CLK_DIV + 1) + MARGIN_CYCLES;
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles", limit);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire

/* testbench/i2c_input.txt */
// command (hex: addr_byte, stop/spare/count, wdata)   expected status   expected rdata
// status: 0 ok, 1 address nack, 2 data nack, 3 bad command
A084A1B2C3D4 0 00000000
A18400000000 0 A1B2C3D4
A08200001234 0 00000000
A18200000000 0 00001234
A18300000000 0 001234C3
A0810000007E 0 00000000
A18100000000 0 0000007E
4482DEADBEEF 1 00000000
458400000000 1 00000000
A08000000055 3 00000000
A18500000000 3 00000000
A00300C0FFEE 0 00000000
A18300000000 0 00C0FFEE
A0010000003C 0 00000000
A10200000000 0 00003CFF
A18400000000 0 3CFFEED4

/* src.f */
design/i2c_pkg.sv
design/i2c_cmd_decode.sv
design/i2c_master_fsm.sv
design/i2c_result_pack.sv
design/i2c_master_top.sv
testbench/i2c_target_model.sv
testbench/i2c_checker.sv
testbench/i2c_master_asserts.sv
testbench/tb_i2c_master.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_i2c_master
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
CLK_DIV    ?= 2
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GCLK_DIV=$(CLK_DIV) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
